// ==== verilog/cpuConsts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath widths
`define WORD_WIDTH 32
`define PC_WIDTH 12 // Instruction and data address
`define REG_ADDR_WIDTH 5
`define IMM_WIDTH 14
`define OPCODE_WIDTH 8

// Instruction field positions, lowest bit of each field
`define RD_LSB 27
`define RA_LSB 22
`define RB_LSB 17
`define SHAMT_LSB 12
`define IMM_LSB 8 // Immediate spans 21 down to 8

// Program counter
`define PC_STEP 4 // One word per instruction
`define PC_RESET 0

`endif

// ==== verilog/cpuPkg.sv ====
`default_nettype none
`include "cpuConsts.svh"

package cpuPkg;
	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`PC_WIDTH-1:0] pcAddr_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

	// Opcode byte, anything not listed decodes as a NOP
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		opNop = 8'h00,
		opAdd = 8'h01,
		opSub = 8'h02,
		opMul = 8'h03,
		opXor = 8'h04,
		opOr = 8'h05,
		opAnd = 8'h06,
		opSll = 8'h07,
		opSra = 8'h08,
		opSrl = 8'h09,
		opSle = 8'h0A,
		opAddi = 8'h10,
		opSlli = 8'h11,
		opLw = 8'h20,
		opSw = 8'h21
	} opcode_t;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluMul, aluXor, aluOr,
		aluAnd, aluSll, aluSra, aluSrl, aluSle
	} aluOp_t;

	// Second ALU operand
	typedef enum logic [1:0] {srcReg, srcImm, srcShamt} operandSrc_t;
endpackage

`default_nettype wire

// ==== verilog/fetchStage.sv ====
`default_nettype none
`include "cpuConsts.svh"

module fetchStage import cpuPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic icacheReady,
	input wire word_t icacheInstr,
	input wire logic hold,
	input wire logic memBusy,
	output pcAddr_t icacheAddress,
	output logic icacheRequest,
	output word_t ifInstr
);

	pcAddr_t pc;
	logic frozen;
	logic accept;

	assign frozen = hold || memBusy;
	assign accept = icacheReady && !frozen; // Instruction taken this cycle

	assign icacheAddress = pc;
	assign icacheRequest = !reset; // Always fetching outside reset

	always_ff @(posedge clk) begin
		if (reset)
			pc <= pcAddr_t'(`PC_RESET);
		else if (accept)
			pc <= pc + pcAddr_t'(`PC_STEP);
	end

	// Fetch/decode register
	always_ff @(posedge clk) begin
		if (reset) begin
			ifInstr <= word_t'(opNop);
		end else if (!frozen) begin
			if (icacheReady)
				ifInstr <= icacheInstr;
			else
				ifInstr <= word_t'(opNop); // Cache miss becomes a bubble
		end
	end

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`default_nettype none
`include "cpuConsts.svh"

module decodeStage import cpuPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire word_t ifInstr,
	input wire logic memBusy,
	input wire logic wbEnable,
	input wire regAddr_t wbAddr,
	input wire word_t wbData,
	output logic hold,
	output aluOp_t idAluOp,
	output operandSrc_t idSrc,
	output logic idRegWrite,
	output logic idMemRead,
	output logic idMemWrite,
	output regAddr_t idRd,
	output regAddr_t idRa,
	output regAddr_t idRb,
	output word_t idA,
	output word_t idB,
	output word_t idImm,
	output regAddr_t idShamt
);

	word_t regFile [2**`REG_ADDR_WIDTH];
	opcode_t opcode;
	regAddr_t rdField;
	regAddr_t raField;
	regAddr_t rbField;
	regAddr_t rbSel;
	logic [`IMM_WIDTH-1:0] immField;
	aluOp_t aluOp;
	operandSrc_t src;
	logic regWrite;
	logic memRead;
	logic memWrite;
	word_t aData;
	word_t bData;

	// Register read with bypass from the write port
	function automatic word_t readReg(regAddr_t addr);
		if (addr == '0)
			return '0;
		else if (wbEnable && addr == wbAddr)
			return wbData;
		return regFile[addr];
	endfunction

	assign opcode = opcode_t'(ifInstr[`OPCODE_WIDTH-1:0]);
	assign rdField = ifInstr[`RD_LSB +: `REG_ADDR_WIDTH];
	assign raField = ifInstr[`RA_LSB +: `REG_ADDR_WIDTH];
	assign rbField = ifInstr[`RB_LSB +: `REG_ADDR_WIDTH];
	assign immField = ifInstr[`IMM_LSB +: `IMM_WIDTH];
	assign rbSel = memWrite ? rdField : rbField; // Store data comes from the rd field

	always_comb begin
		src = srcReg;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		case (opcode)
			opAdd, opSub, opMul, opXor, opOr, opAnd, opSll, opSra, opSrl, opSle:
				regWrite = 1'b1;
			opAddi: begin
				regWrite = 1'b1;
				src = srcImm;
			end
			opSlli: begin
				regWrite = 1'b1;
				src = srcShamt;
			end
			opLw: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				src = srcImm;
			end
			opSw: begin
				memWrite = 1'b1;
				src = srcImm; // Address is ra plus immediate
			end
			default: ;
		endcase
	end

	always_comb begin
		case (opcode)
			opSub: aluOp = aluSub;
			opMul: aluOp = aluMul;
			opXor: aluOp = aluXor;
			opOr: aluOp = aluOr;
			opAnd: aluOp = aluAnd;
			opSll, opSlli: aluOp = aluSll;
			opSra: aluOp = aluSra;
			opSrl: aluOp = aluSrl;
			opSle: aluOp = aluSle;
			default: aluOp = aluAdd;
		endcase
	end

	always_comb begin
		aData = readReg(raField);
		bData = readReg(rbSel);
	end

	always_ff @(posedge clk) begin
		if (wbEnable && wbAddr != '0)
			regFile[wbAddr] <= wbData;
	end

	// Load in decode/execute feeding the instruction being decoded
	assign hold = idMemRead && (idRd == raField || idRd == rbSel);

	always_ff @(posedge clk) begin
		if (reset) begin
			idRegWrite <= 1'b0;
			idMemRead <= 1'b0;
			idMemWrite <= 1'b0;
		end else if (!memBusy) begin
			idRegWrite <= regWrite && !hold;
			idMemRead <= memRead && !hold;
			idMemWrite <= memWrite && !hold;
		end
	end

	always_ff @(posedge clk) begin
		if (!memBusy) begin
			idAluOp <= aluOp;
			idSrc <= src;
			idRd <= rdField;
			idRa <= raField;
			idRb <= rbSel;
			idA <= aData;
			idB <= bData;
			idImm <= {{(`WORD_WIDTH - `IMM_WIDTH){immField[`IMM_WIDTH-1]}}, immField};
			idShamt <= ifInstr[`SHAMT_LSB +: `REG_ADDR_WIDTH];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`default_nettype none

module executeStage import cpuPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic memBusy,
	input wire aluOp_t idAluOp,
	input wire operandSrc_t idSrc,
	input wire logic idRegWrite,
	input wire logic idMemRead,
	input wire logic idMemWrite,
	input wire regAddr_t idRd,
	input wire regAddr_t idRa,
	input wire regAddr_t idRb,
	input wire word_t idA,
	input wire word_t idB,
	input wire word_t idImm,
	input wire regAddr_t idShamt,
	input wire logic wbEnable,
	input wire regAddr_t wbAddr,
	input wire word_t wbData,
	output logic exRegWrite,
	output logic exMemRead,
	output logic exMemWrite,
	output regAddr_t exRd,
	output word_t exResult,
	output word_t exStoreData
);

	word_t opA;
	word_t regB;
	word_t opB;
	word_t aluResult;
	regAddr_t shiftAmount;

	// Newest value of a source register, execute/memory first
	function automatic word_t forwardValue(regAddr_t addr, word_t decoded);
		if (exRegWrite && exRd != '0 && exRd == addr)
			return exResult;
		else if (wbEnable && wbAddr != '0 && wbAddr == addr)
			return wbData;
		return decoded;
	endfunction

	always_comb begin
		opA = forwardValue(idRa, idA);
		regB = forwardValue(idRb, idB); // Also the store data
		case (idSrc)
			srcImm: opB = idImm;
			srcShamt: opB = word_t'(idShamt);
			default: opB = regB;
		endcase
	end

	assign shiftAmount = regAddr_t'(opB);

	always_comb begin
		case (idAluOp)
			aluSub: aluResult = opA - opB;
			aluMul: aluResult = opA * opB;
			aluXor: aluResult = opA ^ opB;
			aluOr: aluResult = opA | opB;
			aluAnd: aluResult = opA & opB;
			aluSll: aluResult = opA << shiftAmount;
			aluSra: aluResult = word_t'($signed(opA) >>> shiftAmount);
			aluSrl: aluResult = opA >> shiftAmount;
			aluSle: aluResult = word_t'(opA <= opB); // Unsigned compare
			default: aluResult = opA + opB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
		end else if (!memBusy) begin
			exRegWrite <= idRegWrite;
			exMemRead <= idMemRead;
			exMemWrite <= idMemWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!memBusy) begin
			exRd <= idRd;
			exResult <= aluResult;
			exStoreData <= regB;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/memoryStage.sv ====
`default_nettype none
`include "cpuConsts.svh"

module memoryStage import cpuPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic exRegWrite,
	input wire logic exMemRead,
	input wire logic exMemWrite,
	input wire regAddr_t exRd,
	input wire word_t exResult,
	input wire word_t exStoreData,
	input wire logic dcacheReady,
	input wire word_t dcacheReadData,
	output pcAddr_t dcacheAddress,
	output logic dcacheRead,
	output logic dcacheWrite,
	output logic memBusy,
	output word_t dcacheWriteData,
	output logic wbEnable,
	output regAddr_t wbAddr,
	output word_t wbData
);

	assign dcacheAddress = exResult[`PC_WIDTH-1:0];
	assign dcacheRead = exMemRead; // Level until the cache answers
	assign dcacheWrite = exMemWrite;
	assign dcacheWriteData = exStoreData;

	// Load still waiting on the data cache
	assign memBusy = dcacheRead && !dcacheReady;

	// Memory/writeback register
	always_ff @(posedge clk) begin
		if (reset)
			wbEnable <= 1'b0;
		else if (!memBusy)
			wbEnable <= exRegWrite;
	end

	always_ff @(posedge clk) begin
		if (!memBusy) begin
			wbAddr <= exRd;
			wbData <= exMemRead ? dcacheReadData : exResult;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cpuCore.sv ====
`default_nettype none

module cpuCore import cpuPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic icacheReady,
	input wire word_t icacheInstr,
	output pcAddr_t icacheAddress,
	output logic icacheRequest,
	input wire logic dcacheReady,
	input wire word_t dcacheReadData,
	output pcAddr_t dcacheAddress,
	output logic dcacheRead,
	output logic dcacheWrite,
	output word_t dcacheWriteData
);

	// Stall controls
	logic hold;
	logic memBusy;

	word_t ifInstr; // Fetch/decode

	// Decode/execute
	aluOp_t idAluOp;
	operandSrc_t idSrc;
	logic idRegWrite;
	logic idMemRead;
	logic idMemWrite;
	regAddr_t idRd;
	regAddr_t idRa;
	regAddr_t idRb;
	word_t idA;
	word_t idB;
	word_t idImm;
	regAddr_t idShamt;

	// Execute/memory
	logic exRegWrite;
	logic exMemRead;
	logic exMemWrite;
	regAddr_t exRd;
	word_t exResult;
	word_t exStoreData;

	// Register file write port
	logic wbEnable;
	regAddr_t wbAddr;
	word_t wbData;

	fetchStage fetch (.*);
	decodeStage decode (.*);
	executeStage execute (.*);
	memoryStage memory (.*);

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`default_nettype none

module clockGen (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int halfPeriod = 20; // 40 ns clock

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Reset held over the first two rising edges
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/cpuCoreTb.sv ====
`default_nettype none
`include "cpuConsts.svh"

module cpuCoreTb import cpuPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int cycleLimit = 600; // 40 instructions, 5 cycles worst case, doubled, plus margin
	localparam int memWords = 1024;

	logic clk;
	logic reset;
	logic icacheReady;
	word_t icacheInstr;
	pcAddr_t icacheAddress;
	logic icacheRequest;
	logic dcacheReady;
	word_t dcacheReadData;
	pcAddr_t dcacheAddress;
	logic dcacheRead;
	logic dcacheWrite;
	word_t dcacheWriteData;

	word_t imem [memWords];
	word_t dmem [memWords];
	word_t refMem [memWords];
	word_t refRegs [2**`REG_ADDR_WIDTH];
	pcAddr_t expAddr [$];
	word_t expData [$];
	int instrCount;
	int storeCount;
	int cycleCount;
	int waitLeft;
	int seedValue;
	logic running;
	pcAddr_t lastPc;
	logic lastIcacheReady;
	logic lastBusy;
	pcAddr_t lastDcacheAddress;

	clockGen clocks (.clk(clk), .reset(reset));

	cpuCore u_dut (.*);

	// Both caches answer in the same cycle as the address
	assign icacheInstr = imem[icacheAddress[`PC_WIDTH-1:2]];
	assign dcacheReadData = dmem[dcacheAddress[`PC_WIDTH-1:2]];

	task automatic stopWithFailure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	function automatic word_t regOp(opcode_t op, regAddr_t rd, regAddr_t ra, regAddr_t rb);
		return (word_t'(rd) << `RD_LSB) | (word_t'(ra) << `RA_LSB)
			| (word_t'(rb) << `RB_LSB) | word_t'(op);
	endfunction

	function automatic word_t immOp(opcode_t op, regAddr_t rd, regAddr_t ra, int imm);
		return (word_t'(rd) << `RD_LSB) | (word_t'(ra) << `RA_LSB)
			| (word_t'(imm[`IMM_WIDTH-1:0]) << `IMM_LSB) | word_t'(op);
	endfunction

	function automatic word_t shiftOp(opcode_t op, regAddr_t rd, regAddr_t ra, regAddr_t shamt);
		return (word_t'(rd) << `RD_LSB) | (word_t'(ra) << `RA_LSB)
			| (word_t'(shamt) << `SHAMT_LSB) | word_t'(op);
	endfunction

	task automatic appendInstr(input word_t instr);
		imem[instrCount] = instr;
		instrCount++;
	endtask

	task automatic fillMemories();
		for (int i = 0; i < memWords; i++) begin
			imem[i] = word_t'(opNop);
			dmem[i] = (word_t'(i) * 32'h9E3779B1) ^ 32'h2468ACE1;
			refMem[i] = dmem[i];
		end
	endtask

	// Straight-line program, every ALU op followed by a store of its result
	task automatic loadProgram();
		instrCount = 0;
		appendInstr(immOp(opAddi, 1, 0, 100));
		appendInstr(immOp(opAddi, 2, 0, 7));
		appendInstr(regOp(opAdd, 3, 1, 2)); // One and two instructions back
		appendInstr(immOp(opSw, 3, 0, 'h100)); // Store data from execute/memory
		appendInstr(regOp(opSub, 4, 1, 2));
		appendInstr(immOp(opSw, 4, 0, 'h104));
		appendInstr(regOp(opMul, 5, 3, 4));
		appendInstr(immOp(opSw, 5, 0, 'h108));
		appendInstr(immOp(opAddi, 6, 0, -1234)); // Negative immediate
		appendInstr(regOp(opXor, 7, 6, 1));
		appendInstr(immOp(opSw, 7, 0, 'h10C));
		appendInstr(regOp(opOr, 8, 6, 2));
		appendInstr(immOp(opSw, 8, 0, 'h110));
		appendInstr(regOp(opAnd, 9, 7, 8));
		appendInstr(immOp(opSw, 9, 0, 'h114));
		appendInstr(regOp(opSll, 10, 1, 2));
		appendInstr(immOp(opSw, 10, 0, 'h118));
		appendInstr(regOp(opSra, 11, 6, 2));
		appendInstr(immOp(opSw, 11, 0, 'h11C));
		appendInstr(regOp(opSrl, 12, 6, 2));
		appendInstr(immOp(opSw, 12, 0, 'h120));
		appendInstr(regOp(opSle, 13, 2, 1));
		appendInstr(regOp(opSle, 14, 1, 2));
		appendInstr(immOp(opSw, 13, 0, 'h124));
		appendInstr(immOp(opSw, 14, 0, 'h128));
		appendInstr(shiftOp(opSlli, 15, 2, 9));
		appendInstr(immOp(opSw, 15, 0, 'h12C));
		appendInstr(immOp(opLw, 16, 0, 'h200));
		appendInstr(regOp(opAdd, 17, 16, 1)); // Load-use
		appendInstr(immOp(opSw, 17, 0, 'h130));
		appendInstr(immOp(opLw, 18, 0, 'h100)); // Reads back an earlier store
		appendInstr(immOp(opSw, 18, 0, 'h134)); // Load-use into store data
		appendInstr(immOp(opLw, 19, 1, 160));
		appendInstr(immOp(opLw, 20, 0, 'h204)); // Back-to-back loads
		appendInstr(regOp(opSub, 21, 20, 19));
		appendInstr(immOp(opSw, 21, 0, 'h138));
		appendInstr(immOp(opAddi, 22, 21, 5));
		appendInstr(regOp(opAdd, 23, 22, 22));
		appendInstr(immOp(opSw, 23, 1, 220));
		appendInstr(immOp(opSw, 22, 0, 'h13C));
	endtask

	// Sequential model of the program, one instruction at a time
	task automatic runReference();
		word_t instr;
		opcode_t op;
		regAddr_t rd;
		word_t a;
		word_t b;
		word_t imm;
		word_t result;
		pcAddr_t addr;
		logic writeRd;
		for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++)
			refRegs[i] = '0;
		for (int pc = 0; pc < memWords; pc++) begin
			instr = imem[pc];
			op = opcode_t'(instr[`OPCODE_WIDTH-1:0]);
			rd = instr[`RD_LSB +: `REG_ADDR_WIDTH];
			a = refRegs[instr[`RA_LSB +: `REG_ADDR_WIDTH]];
			b = refRegs[instr[`RB_LSB +: `REG_ADDR_WIDTH]];
			imm = word_t'($signed(instr[`IMM_LSB +: `IMM_WIDTH]));
			addr = pcAddr_t'(a + imm);
			result = '0;
			writeRd = 1'b1;
			case (op)
				opAdd: result = a + b;
				opSub: result = a - b;
				opMul: result = a * b;
				opXor: result = a ^ b;
				opOr: result = a | b;
				opAnd: result = a & b;
				opSll: result = a << b[4:0];
				opSra: result = word_t'($signed(a) >>> b[4:0]);
				opSrl: result = a >> b[4:0];
				opSle: result = (a <= b) ? 32'd1 : 32'd0;
				opAddi: result = a + imm;
				opSlli: result = a << instr[`SHAMT_LSB +: `REG_ADDR_WIDTH];
				opLw: result = refMem[addr[`PC_WIDTH-1:2]];
				opSw: begin
					refMem[addr[`PC_WIDTH-1:2]] = refRegs[rd];
					expAddr.push_back(addr);
					expData.push_back(refRegs[rd]);
					writeRd = 1'b0;
				end
				default: writeRd = 1'b0;
			endcase
			if (writeRd && rd != '0)
				refRegs[rd] = result;
		end
	endtask

	task automatic checkStore();
		if (storeCount >= expAddr.size()) begin
			stopWithFailure("dcacheWrite strobe beyond the expected number of stores");
		end else begin
			assert (dcacheAddress == expAddr[storeCount]) else
				stopWithFailure($sformatf("mismatch dcacheAddress: expected %h, actual %h",
					expAddr[storeCount], dcacheAddress));
			assert (dcacheWriteData == expData[storeCount]) else
				stopWithFailure($sformatf("mismatch dcacheWriteData: expected %h, actual %h",
					expData[storeCount], dcacheWriteData));
			dmem[dcacheAddress[`PC_WIDTH-1:2]] = dcacheWriteData;
			storeCount++;
		end
	endtask

	always @(posedge clk) begin
		if (reset)
			icacheReady <= 1'b0;
		else
			icacheReady <= ($urandom % 100) < 70;
	end

	// Latency of the next load is picked ahead, ready shows when it runs out
	always @(posedge clk) begin
		if (reset) begin
			waitLeft = $urandom % 4;
			dcacheReady <= (waitLeft == 0);
		end else if (dcacheRead && dcacheReady) begin
			waitLeft = $urandom % 4;
			dcacheReady <= (waitLeft == 0);
		end else if (dcacheRead) begin
			waitLeft = waitLeft - 1;
			dcacheReady <= (waitLeft == 0);
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
			stopWithFailure($sformatf("run exceeded %0d cycles before the last store", cycleLimit));
	end

	// Mid-cycle checks while the program runs
	always @(negedge clk) begin
		if (running) begin
			if (lastBusy)
				assert (dcacheAddress == lastDcacheAddress) else
					stopWithFailure($sformatf("mismatch dcacheAddress: expected %h, actual %h",
						lastDcacheAddress, dcacheAddress));
			if (dcacheRead && !dcacheReady)
				assert (!dcacheWrite) else
					stopWithFailure("dcacheWrite raised while a load waits on the data cache");
			if (icacheAddress != lastPc) begin
				assert (lastIcacheReady) else
					stopWithFailure("icacheAddress moved after a cycle without icacheReady");
				assert (icacheAddress == lastPc + pcAddr_t'(`PC_STEP)) else
					stopWithFailure($sformatf("mismatch icacheAddress: expected %h, actual %h",
						lastPc + pcAddr_t'(`PC_STEP), icacheAddress));
			end
			if (dcacheWrite)
				checkStore();
			lastBusy = dcacheRead && !dcacheReady;
			lastDcacheAddress = dcacheAddress;
			lastPc = icacheAddress;
			lastIcacheReady = icacheReady;
		end
	end

	initial begin
		seedValue = $urandom(66);
		icacheReady = 1'b0;
		dcacheReady = 1'b0;
		storeCount = 0;
		cycleCount = 0;
		running = 1'b0;
		lastBusy = 1'b0;
		fillMemories();
		loadProgram();
		runReference();
		@(negedge reset);
		@(negedge clk);
		assert (!dcacheRead && !dcacheWrite) else
			stopWithFailure("data cache strobe active in the first cycle after reset");
		assert (icacheRequest) else
			stopWithFailure("icacheRequest low in the first cycle after reset");
		assert (icacheAddress == pcAddr_t'(`PC_RESET)) else
			stopWithFailure($sformatf("mismatch icacheAddress: expected %h, actual %h",
				pcAddr_t'(`PC_RESET), icacheAddress));
		lastPc = icacheAddress;
		lastIcacheReady = icacheReady;
		lastDcacheAddress = dcacheAddress;
		running = 1'b1;
		wait (storeCount == expAddr.size());
		repeat (8) @(negedge clk); // Any repeated strobe shows up here
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/cpuPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpuCore.sv
verification/clockGen.sv
verification/cpuCoreTb.sv

// ==== Bender.yml ====
package:
  name: cpuCore

export_include_dirs:
  - verilog

sources:
  - verilog/cpuPkg.sv
  - verilog/fetchStage.sv
  - verilog/decodeStage.sv
  - verilog/executeStage.sv
  - verilog/memoryStage.sv
  - verilog/cpuCore.sv
  - target: test
    files:
      - verification/clockGen.sv
      - verification/cpuCoreTb.sv
